// File: Bender.yml
package:
  name: gray_frame

export_include_dirs:
  - design

sources:
  - files:
      - design/gray_pkg.sv
      - design/frame_buffer.sv
      - design/restoring_divider.sv
      - design/gray_ctrl_regs.sv
      - design/gray_filter_engine.sv
      - design/gray_frame_top.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/gray_frame_checker.sv
      - test/gray_frame_tb.sv

// File: design/frame_buffer.sv
/* Frame memory */

`timescale 1ns/1ps
`default_nettype none

`include "gray_params.svh"

module frame_buffer #(
    parameter type payload_t = gray_pkg::rgb444_t
) (
    input  wire logic              clk_i,
    input  wire logic              wr_en,
    input  wire gray_pkg::pix_addr_t wr_addr,
    input  wire payload_t          wr_data,
    input  wire gray_pkg::pix_addr_t rd_addr,
    output payload_t               rd_data
);

    // One entry per pixel, no reset on contents
    payload_t mem [`GRAY_FRAME_PIXELS];

    // Write port, always accepts
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after address
    always_ff @(posedge clk_i) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: design/gray_ctrl_regs.sv
/* Host control and status registers */

`timescale 1ns/1ps
`default_nettype none

`include "gray_params.svh"

module gray_ctrl_regs (
    input  wire logic               clk_i,
    input  wire logic               rst_i,
    input  wire gray_pkg::cfg_req_t cfg,
    input  wire logic               frame_done,
    output logic                    run_start,
    output logic [`GRAY_ADDR_W:0]   frame_len,
    output gray_pkg::cfg_stat_t     stat
);

    logic                  busy_q;
    logic                  done_q;
    logic [`GRAY_ADDR_W:0] len_q;
    logic                  start_acc;
    logic                  len_wr;

    // Start bit is bit 0 of the control register, taken only when idle
    assign start_acc = cfg.we && (cfg.addr == `GRAY_REG_CTRL) && cfg.data[0] && !busy_q;

    // Length is frozen during a run so the engine sees a stable bound
    assign len_wr = cfg.we && (cfg.addr == `GRAY_REG_LEN) && !busy_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            run_start <= 1'b0;
            len_q     <= (`GRAY_ADDR_W+1)'(`GRAY_FRAME_PIXELS);
        end else begin
            run_start <= start_acc;
            if (start_acc) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (frame_done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
            // Zero or oversize counts fall back to a full frame
            if (len_wr) begin
                if (cfg.data == '0 || cfg.data > `GRAY_FRAME_PIXELS) begin
                    len_q <= (`GRAY_ADDR_W+1)'(`GRAY_FRAME_PIXELS);
                end else begin
                    len_q <= cfg.data;
                end
            end
        end
    end

    assign frame_len = len_q;
    assign stat      = '{busy: busy_q, done: done_q, len: len_q};

endmodule

`default_nettype wire

// File: design/gray_filter_engine.sv
/* Grey conversion engine */

`timescale 1ns/1ps
`default_nettype none

`include "gray_params.svh"

module gray_filter_engine (
    input  wire logic                  clk_i,
    input  wire logic                  rst_i,
    input  wire logic                  run_start,
    input  wire logic [`GRAY_ADDR_W:0] frame_len,
    output logic                       frame_done,
    output gray_pkg::pix_addr_t        src_rd_addr,
    input  wire gray_pkg::rgb444_t     src_rd_data,
    output logic                       div_start,
    output logic [`GRAY_SUM_W-1:0]     div_dividend,
    input  wire logic                  div_done,
    input  wire logic [`GRAY_SUM_W-1:0] div_quotient,
    output gray_pkg::gray_wr_t         dst_wr
);

    import gray_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_SUM,
        ST_WAIT_DIV,
        ST_WRITE,
        ST_FINISH
    } state_t;

    state_t                state_q;
    // Pixels handled so far, also the current address
    logic [`GRAY_ADDR_W:0] pix_cnt_q;
    logic [`GRAY_ADDR_W:0] next_cnt;
    gray_t                 grey;

    assign next_cnt = pix_cnt_q + 1'b1;

    // Quotient of at most 15 fits the low nibble
    assign grey = div_quotient[3:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            pix_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (run_start) begin
                        pix_cnt_q <= '0;
                        state_q   <= ST_FETCH;
                    end
                end
                // Address goes out here, pixel comes back next cycle
                ST_FETCH: state_q <= ST_SUM;
                ST_SUM: state_q <= ST_WAIT_DIV;
                ST_WAIT_DIV: begin
                    if (div_done) begin
                        state_q <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (next_cnt >= frame_len) begin
                        state_q <= ST_FINISH;
                    end else begin
                        pix_cnt_q <= next_cnt;
                        state_q   <= ST_FETCH;
                    end
                end
                ST_FINISH: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign src_rd_addr = pix_cnt_q[`GRAY_ADDR_W-1:0];

    // Channel sum, zero extended so 45 fits
    assign div_dividend = {2'b00, src_rd_data.r}
                        + {2'b00, src_rd_data.g}
                        + {2'b00, src_rd_data.b};
    assign div_start    = (state_q == ST_SUM);

    // Grey pixel lands at the same address it was read from
    assign dst_wr.en   = (state_q == ST_WRITE);
    assign dst_wr.addr = pix_cnt_q[`GRAY_ADDR_W-1:0];
    assign dst_wr.data = grey;

    assign frame_done = (state_q == ST_FINISH);

endmodule

`default_nettype wire

// File: design/gray_frame_top.sv
/* Grey frame filter top */

`timescale 1ns/1ps
`default_nettype none

`include "gray_params.svh"

module gray_frame_top (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic                load_en,
    input  wire gray_pkg::pix_addr_t load_addr,
    input  wire gray_pkg::rgb444_t   load_pixel,
    input  wire gray_pkg::cfg_req_t  cfg,
    output gray_pkg::cfg_stat_t      stat,
    input  wire gray_pkg::pix_addr_t read_addr,
    output gray_pkg::gray_t          read_gray
);

    import gray_pkg::*;

    logic                   run_start;
    logic [`GRAY_ADDR_W:0]  frame_len;
    logic                   frame_done;
    pix_addr_t              src_rd_addr;
    rgb444_t                src_rd_data;
    logic                   div_start;
    logic [`GRAY_SUM_W-1:0] div_dividend;
    logic                   div_done;
    logic [`GRAY_SUM_W-1:0] div_quotient;
    gray_wr_t               dst_wr;

    gray_ctrl_regs regs_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cfg        (cfg),
        .frame_done (frame_done),
        .run_start  (run_start),
        .frame_len  (frame_len),
        .stat       (stat)
    );

    gray_filter_engine engine_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .run_start    (run_start),
        .frame_len    (frame_len),
        .frame_done   (frame_done),
        .src_rd_addr  (src_rd_addr),
        .src_rd_data  (src_rd_data),
        .div_start    (div_start),
        .div_dividend (div_dividend),
        .div_done     (div_done),
        .div_quotient (div_quotient),
        .dst_wr       (dst_wr)
    );

    // Average of three channels, so the divisor is fixed at three
    restoring_divider #(.WIDTH(`GRAY_SUM_W)) div_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start     (div_start),
        .dividend  (div_dividend),
        .divisor   (`GRAY_SUM_W'(3)),
        .done      (div_done),
        .quotient  (div_quotient),
        .remainder ()
    );

    // Colour frame, filled by the host
    frame_buffer #(.payload_t(rgb444_t)) src_buf_i (
        .clk_i   (clk_i),
        .wr_en   (load_en),
        .wr_addr (load_addr),
        .wr_data (load_pixel),
        .rd_addr (src_rd_addr),
        .rd_data (src_rd_data)
    );

    // Grey frame, read back by the host
    frame_buffer #(.payload_t(gray_t)) dst_buf_i (
        .clk_i   (clk_i),
        .wr_en   (dst_wr.en),
        .wr_addr (dst_wr.addr),
        .wr_data (dst_wr.data),
        .rd_addr (read_addr),
        .rd_data (read_gray)
    );

endmodule

`default_nettype wire

// File: design/gray_params.svh
/* Grey filter frame and register constants */

`ifndef GRAY_PARAMS_SVH
`define GRAY_PARAMS_SVH

// Frame geometry, eight columns by four rows
`define GRAY_FRAME_PIXELS 32
`define GRAY_ADDR_W       5

// Largest channel sum is 15 * 3 = 45
`define GRAY_SUM_W        6

// Host register map
`define GRAY_REG_CTRL     1'b0
`define GRAY_REG_LEN      1'b1

`endif

// File: design/gray_pkg.sv
/* Grey filter shared types */

`default_nettype none

`include "gray_params.svh"

package gray_pkg;

    // One colour pixel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    typedef logic [3:0] gray_t;

    typedef logic [`GRAY_ADDR_W-1:0] pix_addr_t;

    // Host register write, data is wide enough for the count 32
    typedef struct packed {
        logic                 we;
        logic                 addr;
        logic [`GRAY_ADDR_W:0] data;
    } cfg_req_t;

    typedef struct packed {
        logic                 busy;
        logic                 done;
        logic [`GRAY_ADDR_W:0] len;
    } cfg_stat_t;

    // Engine write into the grey frame
    typedef struct packed {
        logic      en;
        pix_addr_t addr;
        gray_t     data;
    } gray_wr_t;

endpackage

`default_nettype wire

// File: design/restoring_divider.sv
/* Sequential restoring divider */

`timescale 1ns/1ps
`default_nettype none

`include "gray_params.svh"

module restoring_divider #(
    parameter int WIDTH = `GRAY_SUM_W
) (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire logic             start,
    input  wire logic [WIDTH-1:0] dividend,
    input  wire logic [WIDTH-1:0] divisor,
    output logic                  done,
    output logic [WIDTH-1:0]      quotient,
    output logic [WIDTH-1:0]      remainder
);

    localparam int CNT_W = $clog2(WIDTH + 1);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic [WIDTH-1:0] rem_q;
    // Holds the dividend at first, quotient bits shift in from the right
    logic [WIDTH-1:0] quo_q;
    logic [WIDTH-1:0] div_q;
    logic [WIDTH:0]   shifted;
    logic [WIDTH:0]   trial;

    // Bring down the next dividend bit and try the subtraction
    assign shifted = {rem_q, quo_q[WIDTH-1]};
    assign trial   = shifted - {1'b0, div_q};

    // Control, done goes high after the last of WIDTH steps
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            done   <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done <= 1'b0;
            if (!busy_q) begin
                if (start) begin
                    busy_q <= 1'b1;
                    cnt_q  <= CNT_W'(WIDTH);
                end
            end else begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin
                    busy_q <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    // Datapath, results stay put once the run ends
    always_ff @(posedge clk_i) begin
        if (!busy_q && start) begin
            rem_q <= '0;
            quo_q <= dividend;
            div_q <= divisor;
        end else if (busy_q) begin
            if (trial[WIDTH]) begin
                // Negative trial, restore and shift in a zero
                rem_q <= shifted[WIDTH-1:0];
                quo_q <= {quo_q[WIDTH-2:0], 1'b0};
            end else begin
                rem_q <= trial[WIDTH-1:0];
                quo_q <= {quo_q[WIDTH-2:0], 1'b1};
            end
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

`default_nettype wire

// File: files.f
+incdir+design
design/gray_pkg.sv
design/frame_buffer.sv
design/restoring_divider.sv
design/gray_ctrl_regs.sv
design/gray_filter_engine.sv
design/gray_frame_top.sv
test/clk_gen.sv
test/gray_frame_checker.sv
test/gray_frame_tb.sv

// File: test/clk_gen.sv
/* Testbench clock and reset */

`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES  = 3
) (
    output logic clk_i,
    output logic rst_i
);

    // 10 ns clock
    initial begin
        clk_i = 1'b0;
        forever #(HALF_PERIOD) clk_i = ~clk_i;
    end

    // Synchronous reset held over the first rising edges
    initial begin
        rst_i = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
    end

endmodule

`default_nettype wire

// File: test/gray_frame_checker.sv
/* Filter engine assertions */

`timescale 1ns/1ps
`default_nettype none

`include "gray_params.svh"

module gray_frame_checker (
    input wire logic                  clk_i,
    input wire logic                  rst_i,
    input wire logic                  engine_idle,
    input wire gray_pkg::gray_wr_t    dst_wr,
    input wire logic [`GRAY_ADDR_W:0] frame_len,
    input wire logic                  div_start,
    input wire logic                  div_done,
    input wire gray_pkg::cfg_stat_t   stat
);

    // Failed assertions so far
    int unsigned fail_count = 0;
    // High from div_start until div_done
    logic        div_busy_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            div_busy_q <= 1'b0;
        end else if (div_start) begin
            div_busy_q <= 1'b1;
        end else if (div_done) begin
            div_busy_q <= 1'b0;
        end
    end

    // Grey writes only come from an active engine
    a_wr_active: assert property (@(posedge clk_i) disable iff (rst_i)
        dst_wr.en |-> !engine_idle)
    else begin
        fail_count++;
        $error("Grey write while the engine is idle");
    end

    // Writes stay inside the programmed frame
    a_wr_addr: assert property (@(posedge clk_i) disable iff (rst_i)
        dst_wr.en |-> ({1'b0, dst_wr.addr} < frame_len))
    else begin
        fail_count++;
        $error("Grey write address %0d not below length %0d", dst_wr.addr, frame_len);
    end

    // Single divider, one division at a time
    a_div_single: assert property (@(posedge clk_i) disable iff (rst_i)
        div_start |-> !div_busy_q)
    else begin
        fail_count++;
        $error("Divider started while a division is in flight");
    end

    a_busy_done: assert property (@(posedge clk_i) disable iff (rst_i)
        !(stat.busy && stat.done))
    else begin
        fail_count++;
        $error("Status shows busy and done together");
    end

endmodule

`default_nettype wire

// File: test/gray_frame_tb.sv
/* Grey frame filter testbench */

`timescale 1ns/1ps
`default_nettype none

`include "gray_params.svh"

module gray_frame_tb;

    import gray_pkg::*;

    localparam int NPIX        = `GRAY_FRAME_PIXELS;
    localparam int WAIT_MAX    = 1000;
    // Ten cycles per pixel plus a few cycles of start and finish overhead
    localparam int FRAME_SLACK = 10;
    localparam logic [`GRAY_ADDR_W:0] FULL_LEN = NPIX;

    logic      clk_i;
    logic      rst_i;
    logic      load_en;
    pix_addr_t load_addr;
    rgb444_t   load_pixel;
    cfg_req_t  cfg;
    cfg_stat_t stat;
    pix_addr_t read_addr;
    gray_t     read_gray;

    // Pattern word holds the pixel in bits 15:4 and its grey level in 3:0
    logic [15:0] pattern_mem [NPIX];
    rgb444_t     pixels [NPIX];
    gray_t       grey_exp [NPIX];
    // Expected destination frame for the current run
    gray_t       frame_exp [NPIX];
    int          errors;
    // Free-running cycle count for run length checks
    int unsigned cycle_cnt = 0;

    clk_gen clk_gen_i (
        .clk_i (clk_i),
        .rst_i (rst_i)
    );

    gray_frame_top dut_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_pixel (load_pixel),
        .cfg        (cfg),
        .stat       (stat),
        .read_addr  (read_addr),
        .read_gray  (read_gray)
    );

    // Idle is the first engine state, encoded as zero
    bind gray_frame_top gray_frame_checker chk_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .engine_idle (engine_i.state_q == 3'd0),
        .dst_wr      (dst_wr),
        .frame_len   (frame_len),
        .div_start   (div_start),
        .div_done    (div_done),
        .stat        (stat)
    );

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_gray(input string name, input gray_t expected, input gray_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_stat(input string name, input cfg_stat_t expected,
                              input cfg_stat_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected busy=%b done=%b len=%0d, actual busy=%b done=%b len=%0d",
                     name, expected.busy, expected.done, expected.len,
                     actual.busy, actual.done, actual.len);
        end
    endtask

    // One register write, held for a single cycle
    task automatic reg_write(input logic addr, input logic [`GRAY_ADDR_W:0] data);
        @(posedge clk_i);
        cfg <= cfg_req_t'{we: 1'b1, addr: addr, data: data};
        @(posedge clk_i);
        cfg <= '0;
    endtask

    task automatic load_frame(input bit reverse);
        for (int i = 0; i < NPIX; i++) begin
            @(posedge clk_i);
            load_en    <= 1'b1;
            load_addr  <= pix_addr_t'(i);
            load_pixel <= reverse ? pixels[NPIX-1-i] : pixels[i];
        end
        @(posedge clk_i);
        load_en <= 1'b0;
    endtask

    // Poll done or busy at the falling edge
    task automatic wait_status(input string name, input bit want_done);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while ((want_done ? !stat.done : !stat.busy) && cycles < WAIT_MAX) begin
            @(negedge clk_i);
            cycles++;
        end
        if (want_done ? !stat.done : !stat.busy) begin
            errors++;
            $display("Timeout: %s never raised %s", name, want_done ? "done" : "busy");
        end
    endtask

    task automatic run_frame(input string name);
        reg_write(`GRAY_REG_CTRL, 1);
        wait_status(name, 1'b1);
    endtask

    // Readback has one cycle of latency
    task automatic read_check(input string name, input gray_t expected [NPIX]);
        for (int i = 0; i < NPIX; i++) begin
            @(posedge clk_i);
            read_addr <= pix_addr_t'(i);
            @(posedge clk_i);
            @(negedge clk_i);
            check_gray($sformatf("%s pixel %0d", name, i), expected[i], read_gray);
        end
    endtask

    initial begin
        int          cycles;
        bit          restarted;
        gray_t       avg;
        int unsigned run_begin;
        errors     = 0;
        cycles     = 0;
        restarted  = 1'b0;
        run_begin  = 0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_pixel = '0;
        cfg        = '0;
        read_addr  = '0;

        $readmemh("test/gray_patterns.hex", pattern_mem);
        for (int i = 0; i < NPIX; i++) begin
            pixels[i]   = rgb444_t'(pattern_mem[i][15:4]);
            grey_exp[i] = pattern_mem[i][3:0];
            // Floor of the channel average, to vet the pattern file
            avg = gray_t'((int'(pixels[i].r) + int'(pixels[i].g) + int'(pixels[i].b)) / 3);
            if (avg !== grey_exp[i]) begin
                errors++;
                $display("Mismatch pattern line %0d: expected %h, actual %h",
                         i, avg, grey_exp[i]);
            end
        end

        while (rst_i !== 1'b0 && cycles < WAIT_MAX) begin
            @(posedge clk_i);
            cycles++;
        end
        if (rst_i !== 1'b0) begin
            errors++;
            $display("Timeout: reset was never released");
        end
        @(negedge clk_i);
        check_stat("after reset", cfg_stat_t'{busy: 1'b0, done: 1'b0, len: FULL_LEN}, stat);

        // Full frame in load order
        load_frame(1'b0);
        run_frame("full frame");
        check_stat("full frame", cfg_stat_t'{busy: 1'b0, done: 1'b1, len: FULL_LEN}, stat);
        read_check("full frame", grey_exp);

        // Second start during the run must be dropped
        reg_write(`GRAY_REG_CTRL, 1);
        run_begin = cycle_cnt;
        wait_status("rerun", 1'b0);
        // Second start lands about half way through the frame
        repeat (NPIX * 5) @(posedge clk_i);
        reg_write(`GRAY_REG_CTRL, 1);
        wait_status("start while busy", 1'b1);
        if (cycle_cnt - run_begin > 10 * NPIX + FRAME_SLACK) begin
            errors++;
            $display("A start written during a run restarted the frame");
        end
        repeat (40) begin
            @(negedge clk_i);
            if (stat.busy || !stat.done) begin
                restarted = 1'b1;
            end
        end
        if (restarted) begin
            errors++;
            $display("A start written during a run launched another run");
        end
        check_stat("start while busy", cfg_stat_t'{busy: 1'b0, done: 1'b1, len: FULL_LEN},
                   stat);
        read_check("start while busy", grey_exp);

        // Reversed frame, only the first 20 pixels converted
        load_frame(1'b1);
        reg_write(`GRAY_REG_LEN, 20);
        @(negedge clk_i);
        check_stat("length 20", cfg_stat_t'{busy: 1'b0, done: 1'b1, len: 20}, stat);
        run_frame("length 20");
        for (int i = 0; i < NPIX; i++) begin
            frame_exp[i] = (i < 20) ? grey_exp[NPIX-1-i] : grey_exp[i];
        end
        read_check("length 20", frame_exp);

        // Zero length falls back to the whole frame
        reg_write(`GRAY_REG_LEN, 0);
        @(negedge clk_i);
        check_stat("length clamp", cfg_stat_t'{busy: 1'b0, done: 1'b1, len: FULL_LEN}, stat);
        run_frame("clamped length");
        for (int i = 0; i < NPIX; i++) begin
            frame_exp[i] = grey_exp[NPIX-1-i];
        end
        read_check("clamped length", frame_exp);

        $display("Checks done: %0d errors, %0d assertion failures",
                 errors, dut_i.chk_i.fail_count);
        if (errors == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/gray_patterns.hex
// One word per pixel: three hex digits of RGB444 (r g b), then the expected grey digit
// Grey is floor((r + g + b) / 3)
0000
ffff
1232
4565
7898
abcb
defe
1000
0100
0010
1111
2000
2201
f005
0f05
00f5
ff0a
0ffa
f0fa
3212
8888
7777
9a58
3c77
e215
5b05
68d9
c4a8
2e98
b3f9
1d66
eefe
